/* project.f */
hdl/floo_chimney_pkg.sv
hdl/floo_aw_w_packer.sv
hdl/floo_ar_packer.sv
hdl/floo_wormhole_arbiter.sv
hdl/floo_rsp_unpacker.sv
hdl/floo_axi_chimney.sv
tests/tb_clock_gen.sv
tests/tb_floo_axi_chimney.sv

/* run.sh */
#!/bin/sh
# Build the chimney testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tb_floo_axi_chimney \
  -o sim_tb > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulator exited with an error"
grep -q "^Test passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* tests/tb_floo_axi_chimney.sv */
//////////////////////////////////////////////////
// Chimney testbench: request and response tables,
// channel drivers, flit checkers and the report
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_floo_axi_chimney;

  import floo_chimney_pkg::*;

  localparam node_id_t NodeId  = 4'hA;
  localparam node_id_t PeerId  = 4'h3;
  localparam int       NumReq  = 8;
  localparam int       NumRsp  = 6;
  localparam int       Timeout = 1000;

  typedef struct packed {
    logic                  is_write;
    logic [AxiIdWidth-1:0] id;
    logic [AddrWidth-1:0]  addr;
    logic [7:0]            len;
    logic [DataWidth-1:0]  seed;
  } req_entry_t;

  typedef struct packed {
    logic                  is_b;
    logic [AxiIdWidth-1:0] id;
    logic [DataWidth-1:0]  data;
    logic [1:0]            resp;
    logic                  last;
  } rsp_entry_t;

  // Expected request flit tagged with its table row
  typedef struct packed {
    logic [7:0] idx;
    floo_flit_t flit;
  } exp_req_t;

  logic         clk;
  logic         reset;
  axi_ax_chan_t aw_i;
  logic         aw_valid_i;
  logic         aw_ready_o;
  axi_w_chan_t  w_i;
  logic         w_valid_i;
  logic         w_ready_o;
  axi_ax_chan_t ar_i;
  logic         ar_valid_i;
  logic         ar_ready_o;
  axi_b_chan_t  b_o;
  logic         b_valid_o;
  logic         b_ready_i;
  axi_r_chan_t  r_o;
  logic         r_valid_o;
  logic         r_ready_i;
  floo_flit_t   floo_req_o;
  logic         floo_req_valid_o;
  logic         floo_req_ready_i;
  floo_flit_t   floo_rsp_i;
  logic         floo_rsp_valid_i;
  logic         floo_rsp_ready_o;

  integer       seed;
  int           errors;
  int           checks;
  req_entry_t   req_tab[NumReq];
  string        req_name[NumReq];
  int           req_err[NumReq];
  rsp_entry_t   rsp_tab[NumRsp];
  string        rsp_name[NumRsp];
  exp_req_t     exp_aw[$];
  exp_req_t     exp_w[$];
  exp_req_t     exp_ar[$];
  int           b_idx_q[$];
  int           r_idx_q[$];

  tb_clock_gen i_clock_gen (
    .clk_o   ( clk   ),
    .reset_o ( reset )
  );

  floo_axi_chimney #(
    .NodeId ( NodeId )
  ) uut (
    .clk_i            ( clk              ),
    .reset_i          ( reset            ),
    .aw_i             ( aw_i             ),
    .aw_valid_i       ( aw_valid_i       ),
    .aw_ready_o       ( aw_ready_o       ),
    .w_i              ( w_i              ),
    .w_valid_i        ( w_valid_i        ),
    .w_ready_o        ( w_ready_o        ),
    .ar_i             ( ar_i             ),
    .ar_valid_i       ( ar_valid_i       ),
    .ar_ready_o       ( ar_ready_o       ),
    .b_o              ( b_o              ),
    .b_valid_o        ( b_valid_o        ),
    .b_ready_i        ( b_ready_i        ),
    .r_o              ( r_o              ),
    .r_valid_o        ( r_valid_o        ),
    .r_ready_i        ( r_ready_i        ),
    .floo_req_o       ( floo_req_o       ),
    .floo_req_valid_o ( floo_req_valid_o ),
    .floo_req_ready_i ( floo_req_ready_i ),
    .floo_rsp_i       ( floo_rsp_i       ),
    .floo_rsp_valid_i ( floo_rsp_valid_i ),
    .floo_rsp_ready_o ( floo_rsp_ready_o )
  );

  //////////////////////////////////////////////////
  // Tables
  //////////////////////////////////////////////////

  task automatic load_tables();
    req_tab[0]  = '{1'b1, 4'h1, 32'h0000_0100, 8'd0, 32'h1111_0000};
    req_name[0] = "wr_single_rule0";
    req_tab[1]  = '{1'b0, 4'h2, 32'h1000_0800, 8'd1, 32'h0};
    req_name[1] = "rd_rule1";
    req_tab[2]  = '{1'b1, 4'h3, 32'h2000_0040, 8'd3, 32'h2222_0000};
    req_name[2] = "wr_burst_rule2";
    req_tab[3]  = '{1'b0, 4'h4, 32'h8000_0000, 8'd0, 32'h0};
    req_name[3] = "rd_unmapped";
    req_tab[4]  = '{1'b1, 4'h5, 32'h3abc_0000, 8'd5, 32'h3333_0000};
    req_name[4] = "wr_burst_rule3";
    req_tab[5]  = '{1'b0, 4'h6, 32'h3000_0010, 8'd7, 32'h0};
    req_name[5] = "rd_rule3";
    req_tab[6]  = '{1'b1, 4'h7, 32'hf000_0000, 8'd2, 32'h4444_0000};
    req_name[6] = "wr_unmapped";
    req_tab[7]  = '{1'b0, 4'h8, 32'h0fff_fffc, 8'd0, 32'h0};
    req_name[7] = "rd_rule0_top";
    rsp_tab[0]  = '{1'b1, 4'h1, 32'h0, 2'b00, 1'b1};
    rsp_name[0] = "b_okay";
    rsp_tab[1]  = '{1'b0, 4'h2, 32'hcafe_0001, 2'b00, 1'b0};
    rsp_name[1] = "r_beat0";
    rsp_tab[2]  = '{1'b0, 4'h2, 32'hcafe_0002, 2'b00, 1'b1};
    rsp_name[2] = "r_beat1";
    rsp_tab[3]  = '{1'b1, 4'h3, 32'h0, 2'b10, 1'b1};
    rsp_name[3] = "b_slverr";
    rsp_tab[4]  = '{1'b0, 4'h4, 32'h1234_5678, 2'b11, 1'b1};
    rsp_name[4] = "r_decerr";
    rsp_tab[5]  = '{1'b1, 4'h5, 32'h0, 2'b01, 1'b1};
    rsp_name[5] = "b_exokay";
  endtask

  // Four 256 MiB regions from address 0 go to nodes 1 to 4
  function automatic node_id_t expected_dst(input logic [AddrWidth-1:0] addr);
    if (addr < 32'h4000_0000) begin
      return addr[31:28] + 4'd1;
    end
    return 4'd0;
  endfunction

  function automatic floo_flit_t make_flit(input axi_ch_e ch, input node_id_t dst,
                                           input node_id_t src, input logic last,
                                           input logic [PayloadWidth-1:0] body);
    floo_flit_t flit;
    flit            = '0;
    flit.hdr.dst_id = dst;
    flit.hdr.src_id = src;
    flit.hdr.axi_ch = ch;
    flit.hdr.last   = last;
    flit.payload    = body;
    return flit;
  endfunction

  function automatic axi_ax_chan_t ax_of(input int i);
    axi_ax_chan_t ax;
    ax.id   = req_tab[i].id;
    ax.addr = req_tab[i].addr;
    ax.len  = req_tab[i].len;
    return ax;
  endfunction

  function automatic axi_w_chan_t w_beat_of(input int i, input int beat);
    axi_w_chan_t w;
    w.data = req_tab[i].seed + 32'(beat);
    w.strb = 4'hf;
    w.last = (beat == int'(req_tab[i].len));
    return w;
  endfunction

  function automatic axi_b_chan_t b_of(input int i);
    axi_b_chan_t b;
    b.id   = rsp_tab[i].id;
    b.resp = rsp_tab[i].resp;
    return b;
  endfunction

  function automatic axi_r_chan_t r_of(input int i);
    axi_r_chan_t r;
    r.id   = rsp_tab[i].id;
    r.data = rsp_tab[i].data;
    r.resp = rsp_tab[i].resp;
    r.last = rsp_tab[i].last;
    return r;
  endfunction

  function automatic floo_flit_t rsp_flit_of(input int i);
    if (rsp_tab[i].is_b) begin
      return make_flit(AxiB, NodeId, PeerId, 1'b1, PayloadWidth'(b_of(i)));
    end
    return make_flit(AxiR, NodeId, PeerId, 1'b1, PayloadWidth'(r_of(i)));
  endfunction

  // Per-channel expected queues in table order
  task automatic build_expected();
    exp_req_t e;
    node_id_t dst;
    for (int i = 0; i < NumReq; i++) begin
      e.idx = 8'(i);
      dst   = expected_dst(req_tab[i].addr);
      if (req_tab[i].is_write) begin
        e.flit = make_flit(AxiAw, dst, NodeId, 1'b0, PayloadWidth'(ax_of(i)));
        exp_aw.push_back(e);
        for (int beat = 0; beat <= int'(req_tab[i].len); beat++) begin
          e.flit = make_flit(AxiW, dst, NodeId, (beat == int'(req_tab[i].len)),
                             PayloadWidth'(w_beat_of(i, beat)));
          exp_w.push_back(e);
        end
      end else begin
        e.flit = make_flit(AxiAr, dst, NodeId, 1'b1, PayloadWidth'(ax_of(i)));
        exp_ar.push_back(e);
      end
    end
    for (int i = 0; i < NumRsp; i++) begin
      if (rsp_tab[i].is_b) begin
        b_idx_q.push_back(i);
      end else begin
        r_idx_q.push_back(i);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////

  function automatic logic ready_of(input int ch);
    case (ch)
      0:       return aw_ready_o;
      1:       return w_ready_o;
      2:       return ar_ready_o;
      default: return floo_rsp_ready_o;
    endcase
  endfunction

  // Returns on the rising edge where the item was taken
  task automatic wait_ready(input int ch, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!ready_of(ch) && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!ready_of(ch)) begin
      $display("Timeout: %s was never accepted by the chimney", what);
      errors++;
    end
    @(posedge clk);
  endtask

  task automatic drive_aw();
    for (int i = 0; i < NumReq; i++) begin
      if (req_tab[i].is_write) begin
        aw_i       <= ax_of(i);
        aw_valid_i <= 1'b1;
        wait_ready(0, req_name[i]);
      end
    end
    aw_valid_i <= 1'b0;
  endtask

  task automatic drive_w();
    for (int i = 0; i < NumReq; i++) begin
      if (req_tab[i].is_write) begin
        for (int beat = 0; beat <= int'(req_tab[i].len); beat++) begin
          w_i       <= w_beat_of(i, beat);
          w_valid_i <= 1'b1;
          wait_ready(1, req_name[i]);
        end
      end
    end
    w_valid_i <= 1'b0;
  endtask

  task automatic drive_ar();
    for (int i = 0; i < NumReq; i++) begin
      if (!req_tab[i].is_write) begin
        ar_i       <= ax_of(i);
        ar_valid_i <= 1'b1;
        wait_ready(2, req_name[i]);
      end
    end
    ar_valid_i <= 1'b0;
  endtask

  task automatic drive_rsp();
    for (int i = 0; i < NumRsp; i++) begin
      floo_rsp_i       <= rsp_flit_of(i);
      floo_rsp_valid_i <= 1'b1;
      wait_ready(3, rsp_name[i]);
    end
    floo_rsp_valid_i <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Checkers
  //////////////////////////////////////////////////

  task automatic check_req();
    int         cycles;
    floo_flit_t got;
    exp_req_t   want;
    logic       found;
    logic       in_write;
    cycles   = 0;
    in_write = 1'b0;
    while ((exp_aw.size() + exp_w.size() + exp_ar.size()) > 0 && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
      if (floo_req_valid_o && floo_req_ready_i) begin
        cycles = 0;
        got    = floo_req_o;
        found  = 1'b0;
        case (got.hdr.axi_ch)
          AxiAw: begin
            found = (exp_aw.size() > 0);
            if (found) begin
              want = exp_aw.pop_front();
            end
            in_write = 1'b1;
          end
          AxiW: begin
            found = (exp_w.size() > 0);
            if (found) begin
              want = exp_w.pop_front();
            end
            in_write = !got.hdr.last;
          end
          AxiAr: begin
            found = (exp_ar.size() > 0);
            if (found) begin
              want = exp_ar.pop_front();
            end
            // Wormhole must keep reads out of an open write
            if (found && in_write) begin
              $display("Read %s slipped into a write burst", req_name[want.idx]);
              req_err[want.idx]++;
              errors++;
            end
          end
          default: found = 1'b0;
        endcase
        if (!found) begin
          $display("Unexpected request flit %h on the link", got);
          errors++;
        end else begin
          checks++;
          if (got !== want.flit) begin
            $display("FAIL %s: expected %h, got %h", req_name[want.idx], want.flit, got);
            req_err[want.idx]++;
            errors++;
          end
          if (want.flit.hdr.last) begin
            $display("%s finished with %0d error(s)", req_name[want.idx], req_err[want.idx]);
          end
        end
      end
    end
    if ((exp_aw.size() + exp_w.size() + exp_ar.size()) > 0) begin
      $display("Timeout: request flits stopped arriving on the link");
      errors++;
    end
  endtask

  task automatic check_rsp();
    int idx;
    int cycles;
    cycles = 0;
    while ((b_idx_q.size() + r_idx_q.size()) > 0 && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
      if (b_valid_o && b_ready_i) begin
        cycles = 0;
        if (b_idx_q.size() == 0) begin
          $display("Unexpected B response %h", b_o);
          errors++;
        end else begin
          idx = b_idx_q.pop_front();
          checks++;
          if (b_o !== b_of(idx)) begin
            $display("FAIL %s: expected %h, got %h", rsp_name[idx], b_of(idx), b_o);
            errors++;
          end
          $display("%s finished", rsp_name[idx]);
        end
      end
      if (r_valid_o && r_ready_i) begin
        cycles = 0;
        if (r_idx_q.size() == 0) begin
          $display("Unexpected R response %h", r_o);
          errors++;
        end else begin
          idx = r_idx_q.pop_front();
          checks++;
          if (r_o !== r_of(idx)) begin
            $display("FAIL %s: expected %h, got %h", rsp_name[idx], r_of(idx), r_o);
            errors++;
          end
          $display("%s finished", rsp_name[idx]);
        end
      end
    end
    if ((b_idx_q.size() + r_idx_q.size()) > 0) begin
      $display("Timeout: B or R responses stopped arriving");
      errors++;
    end
  endtask

  // Nothing may show up once every expected item is through
  task automatic watch_idle();
    repeat (20) begin
      @(negedge clk);
      if ((floo_req_valid_o && floo_req_ready_i) || (b_valid_o && b_ready_i)
          || (r_valid_o && r_ready_i)) begin
        $display("Extra transfer seen after all expected traffic");
        errors++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Back-pressure and main sequence
  //////////////////////////////////////////////////

  initial begin
    seed             = 32'hdea2;
    floo_req_ready_i = 1'b0;
    b_ready_i        = 1'b0;
    r_ready_i        = 1'b0;
    forever begin
      @(posedge clk);
      floo_req_ready_i <= (($random(seed) & 3) != 0);
      b_ready_i        <= (($random(seed) & 1) != 0);
      r_ready_i        <= (($random(seed) & 1) != 0);
    end
  end

  initial begin : main
    int cycles;
    aw_i             = '0;
    aw_valid_i       = 1'b0;
    w_i              = '0;
    w_valid_i        = 1'b0;
    ar_i             = '0;
    ar_valid_i       = 1'b0;
    floo_rsp_i       = '0;
    floo_rsp_valid_i = 1'b0;
    errors           = 0;
    checks           = 0;
    for (int i = 0; i < NumReq; i++) begin
      req_err[i] = 0;
    end
    load_tables();
    build_expected();
    cycles = 0;
    while (reset && cycles < Timeout) begin
      @(posedge clk);
      cycles++;
    end
    if (reset) begin
      $display("Reset was never released");
      errors++;
    end else begin
      @(negedge clk);
      checks++;
      if ({floo_req_valid_o, b_valid_o, r_valid_o} !== 3'b000) begin
        $display("FAIL reset_values: expected %b, got %b", 3'b000,
                 {floo_req_valid_o, b_valid_o, r_valid_o});
        errors++;
      end
      $display("reset_values finished");
      @(posedge clk);
      fork
        drive_aw();
        drive_w();
        drive_ar();
        drive_rsp();
        check_req();
        check_rsp();
      join
      watch_idle();
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", NumReq + NumRsp + 1, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* tests/tb_clock_gen.sv */
//////////////////////////////////////////////////
// Testbench clock (10 ns period) and a reset held
// for the first two rising edges
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #5 clk_o = ~clk_o;
    end
  end

  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

/* hdl/floo_axi_chimney.sv */
//////////////////////////////////////////////////
// Manager-side AXI chimney top level: packers,
// request arbiter and response unpacker
//////////////////////////////////////////////////

`timescale 1ns/1ps

module floo_axi_chimney #(
  parameter floo_chimney_pkg::node_id_t NodeId = 4'hA
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  // AXI requests from the local manager
  input  floo_chimney_pkg::axi_ax_chan_t aw_i,
  input  logic                           aw_valid_i,
  output logic                           aw_ready_o,
  input  floo_chimney_pkg::axi_w_chan_t  w_i,
  input  logic                           w_valid_i,
  output logic                           w_ready_o,
  input  floo_chimney_pkg::axi_ax_chan_t ar_i,
  input  logic                           ar_valid_i,
  output logic                           ar_ready_o,
  // AXI responses back to the manager
  output floo_chimney_pkg::axi_b_chan_t  b_o,
  output logic                           b_valid_o,
  input  logic                           b_ready_i,
  output floo_chimney_pkg::axi_r_chan_t  r_o,
  output logic                           r_valid_o,
  input  logic                           r_ready_i,
  // NoC links
  output floo_chimney_pkg::floo_flit_t   floo_req_o,
  output logic                           floo_req_valid_o,
  input  logic                           floo_req_ready_i,
  input  floo_chimney_pkg::floo_flit_t   floo_rsp_i,
  input  logic                           floo_rsp_valid_i,
  output logic                           floo_rsp_ready_o
);

  import floo_chimney_pkg::*;

  // Arbiter input 0 is AW/W, input 1 is AR
  floo_flit_t [1:0] arb_flit;
  logic [1:0]       arb_valid;
  logic [1:0]       arb_ready;

  floo_aw_w_packer #(
    .NodeId ( NodeId )
  ) i_aw_w_packer (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .aw_i         ( aw_i         ),
    .aw_valid_i   ( aw_valid_i   ),
    .aw_ready_o   ( aw_ready_o   ),
    .w_i          ( w_i          ),
    .w_valid_i    ( w_valid_i    ),
    .w_ready_o    ( w_ready_o    ),
    .flit_o       ( arb_flit[0]  ),
    .flit_valid_o ( arb_valid[0] ),
    .flit_ready_i ( arb_ready[0] )
  );

  floo_ar_packer #(
    .NodeId ( NodeId )
  ) i_ar_packer (
    .clk_i        ( clk_i        ),
    .ar_i         ( ar_i         ),
    .ar_valid_i   ( ar_valid_i   ),
    .ar_ready_o   ( ar_ready_o   ),
    .flit_o       ( arb_flit[1]  ),
    .flit_valid_o ( arb_valid[1] ),
    .flit_ready_i ( arb_ready[1] )
  );

  floo_wormhole_arbiter i_req_arbiter (
    .clk_i       ( clk_i            ),
    .reset_i     ( reset_i          ),
    .in_flit_i   ( arb_flit         ),
    .in_valid_i  ( arb_valid        ),
    .in_ready_o  ( arb_ready        ),
    .out_flit_o  ( floo_req_o       ),
    .out_valid_o ( floo_req_valid_o ),
    .out_ready_i ( floo_req_ready_i )
  );

  floo_rsp_unpacker i_rsp_unpacker (
    .clk_i        ( clk_i            ),
    .reset_i      ( reset_i          ),
    .flit_i       ( floo_rsp_i       ),
    .flit_valid_i ( floo_rsp_valid_i ),
    .flit_ready_o ( floo_rsp_ready_o ),
    .b_o          ( b_o              ),
    .b_valid_o    ( b_valid_o        ),
    .b_ready_i    ( b_ready_i        ),
    .r_o          ( r_o              ),
    .r_valid_o    ( r_valid_o        ),
    .r_ready_i    ( r_ready_i        )
  );

endmodule

/* hdl/floo_rsp_unpacker.sv */
//////////////////////////////////////////////////
// Response unpacker: steers B and R flits into
// registered AXI B and R outputs
//////////////////////////////////////////////////

`timescale 1ns/1ps

module floo_rsp_unpacker (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  floo_chimney_pkg::floo_flit_t  flit_i,
  input  logic                          flit_valid_i,
  output logic                          flit_ready_o,
  output floo_chimney_pkg::axi_b_chan_t b_o,
  output logic                          b_valid_o,
  input  logic                          b_ready_i,
  output floo_chimney_pkg::axi_r_chan_t r_o,
  output logic                          r_valid_o,
  input  logic                          r_ready_i
);

  import floo_chimney_pkg::*;

  axi_b_chan_t b_q;
  axi_r_chan_t r_q;
  logic        b_valid_q;
  logic        r_valid_q;
  logic        b_free;
  logic        r_free;
  logic        b_load;
  logic        r_load;

  assign b_free = !b_valid_q || b_ready_i;
  assign r_free = !r_valid_q || r_ready_i;

  // Ready follows the register the tag points at
  always_comb begin
    case (flit_i.hdr.axi_ch)
      AxiB:    flit_ready_o = b_free;
      AxiR:    flit_ready_o = r_free;
      default: flit_ready_o = 1'b1;  // stray tags are dropped
    endcase
  end

  assign b_load = flit_valid_i && b_free && (flit_i.hdr.axi_ch == AxiB);
  assign r_load = flit_valid_i && r_free && (flit_i.hdr.axi_ch == AxiR);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (b_load) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (r_load) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (b_load) begin
      b_q <= flit_i.payload[$bits(axi_b_chan_t)-1:0];
    end
    if (r_load) begin
      r_q <= flit_i.payload[$bits(axi_r_chan_t)-1:0];
    end
  end

  assign b_o       = b_q;
  assign b_valid_o = b_valid_q;
  assign r_o       = r_q;
  assign r_valid_o = r_valid_q;

  a_rsp_tag: assert property (
    @(posedge clk_i) disable iff (reset_i)
    flit_valid_i |-> (flit_i.hdr.axi_ch inside {AxiB, AxiR})
  );

endmodule

/* hdl/floo_wormhole_arbiter.sv */
//////////////////////////////////////////////////
// Two-input round-robin request arbiter with a
// wormhole lock and a one-entry output register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module floo_wormhole_arbiter (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  floo_chimney_pkg::floo_flit_t [1:0] in_flit_i,
  input  logic [1:0]                         in_valid_i,
  output logic [1:0]                         in_ready_o,
  output floo_chimney_pkg::floo_flit_t       out_flit_o,
  output logic                               out_valid_o,
  input  logic                               out_ready_i
);

  import floo_chimney_pkg::*;

  floo_flit_t out_q;
  logic       out_valid_q;
  logic       locked_q;
  logic       lock_idx_q;
  logic       prio_q;
  logic       gnt_valid;
  logic       gnt_idx;
  logic       load;
  logic       fire;

  // Register can take a flit when empty or draining this cycle
  assign load = !out_valid_q || out_ready_i;

  always_comb begin
    gnt_valid = 1'b0;
    gnt_idx   = prio_q;
    if (locked_q) begin
      gnt_valid = in_valid_i[lock_idx_q];
      gnt_idx   = lock_idx_q;
    end else if (in_valid_i[prio_q]) begin
      gnt_valid = 1'b1;
      gnt_idx   = prio_q;
    end else if (in_valid_i[!prio_q]) begin
      gnt_valid = 1'b1;
      gnt_idx   = !prio_q;
    end
  end

  assign fire = load && gnt_valid;

  always_comb begin
    in_ready_o          = '0;
    in_ready_o[gnt_idx] = load && gnt_valid;
  end

  //////////////////////////////////////////////////
  // Lock, priority and output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_q <= 1'b0;
      locked_q    <= 1'b0;
      lock_idx_q  <= 1'b0;
      prio_q      <= 1'b0;
    end else if (fire) begin
      out_valid_q <= 1'b1;
      locked_q    <= !in_flit_i[gnt_idx].hdr.last;
      lock_idx_q  <= gnt_idx;
      // Hand priority over once a whole packet has passed
      if (in_flit_i[gnt_idx].hdr.last) begin
        prio_q <= !gnt_idx;
      end
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      out_q <= in_flit_i[gnt_idx];
    end
  end

  assign out_flit_o  = out_q;
  assign out_valid_o = out_valid_q;

  a_out_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_flit_o))
  );

endmodule

/* hdl/floo_ar_packer.sv */
//////////////////////////////////////////////////
// AR packer: one single-flit request per AR
//////////////////////////////////////////////////

`timescale 1ns/1ps

module floo_ar_packer #(
  parameter floo_chimney_pkg::node_id_t NodeId = 4'hA
) (
  // Clock only feeds the handshake check below
  input  logic                           clk_i,
  input  floo_chimney_pkg::axi_ax_chan_t ar_i,
  input  logic                           ar_valid_i,
  output logic                           ar_ready_o,
  output floo_chimney_pkg::floo_flit_t   flit_o,
  output logic                           flit_valid_o,
  input  logic                           flit_ready_i
);

  import floo_chimney_pkg::*;

  assign flit_valid_o = ar_valid_i;
  assign ar_ready_o   = flit_ready_i;

  always_comb begin
    flit_o            = '0;
    flit_o.hdr.dst_id = sam_lookup(ar_i.addr);
    flit_o.hdr.src_id = NodeId;
    flit_o.hdr.axi_ch = AxiAr;
    // A read request never holds the link beyond one flit
    flit_o.hdr.last   = 1'b1;
    flit_o.payload[$bits(axi_ax_chan_t)-1:0] = ar_i;
  end

  // Manager must hold AR while it waits for ready
  a_ar_stable: assert property (
    @(posedge clk_i)
    (ar_valid_i && !ar_ready_o) |=> (ar_valid_i && $stable(ar_i))
  );

endmodule

/* hdl/floo_aw_w_packer.sv */
//////////////////////////////////////////////////
// AW/W packer: turns each write burst into one AW
// flit followed by its W flits, same destination
//////////////////////////////////////////////////

`timescale 1ns/1ps

module floo_aw_w_packer #(
  parameter floo_chimney_pkg::node_id_t NodeId = 4'hA
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  floo_chimney_pkg::axi_ax_chan_t aw_i,
  input  logic                           aw_valid_i,
  output logic                           aw_ready_o,
  input  floo_chimney_pkg::axi_w_chan_t  w_i,
  input  logic                           w_valid_i,
  output logic                           w_ready_o,
  output floo_chimney_pkg::floo_flit_t   flit_o,
  output logic                           flit_valid_o,
  input  logic                           flit_ready_i
);

  import floo_chimney_pkg::*;

  typedef enum logic {SelAw, SelW} aw_w_sel_e;

  aw_w_sel_e aw_w_sel_q;
  node_id_t  aw_dst;
  node_id_t  w_dst_q;
  logic      aw_fire;
  logic      w_fire;

  assign aw_dst = sam_lookup(aw_i.addr);

  // Only the channel matching the current state sees the arbiter ready
  assign aw_ready_o   = (aw_w_sel_q == SelAw) && flit_ready_i;
  assign w_ready_o    = (aw_w_sel_q == SelW) && flit_ready_i;
  assign flit_valid_o = (aw_w_sel_q == SelAw) ? aw_valid_i : w_valid_i;

  assign aw_fire = aw_valid_i && aw_ready_o;
  assign w_fire  = w_valid_i && w_ready_o;

  //////////////////////////////////////////////////
  // Flit build
  //////////////////////////////////////////////////

  always_comb begin
    flit_o            = '0;
    flit_o.hdr.src_id = NodeId;
    if (aw_w_sel_q == SelAw) begin
      flit_o.hdr.dst_id = aw_dst;
      flit_o.hdr.axi_ch = AxiAw;
      // AW opens a wormhole that the last W closes
      flit_o.hdr.last   = 1'b0;
      flit_o.payload[$bits(axi_ax_chan_t)-1:0] = aw_i;
    end else begin
      flit_o.hdr.dst_id = w_dst_q;
      flit_o.hdr.axi_ch = AxiW;
      flit_o.hdr.last   = w_i.last;
      flit_o.payload[$bits(axi_w_chan_t)-1:0] = w_i;
    end
  end

  //////////////////////////////////////////////////
  // Burst state
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_w_sel_q <= SelAw;
    end else if (aw_fire) begin
      aw_w_sel_q <= SelW;
    end else if (w_fire && w_i.last) begin
      aw_w_sel_q <= SelAw;
    end
  end

  // W beats follow the destination of their AW
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      w_dst_q <= aw_dst;
    end
  end

  // Manager must hold a W beat while it waits for its AW or for ready
  a_w_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (w_valid_i && !w_ready_o) |=> (w_valid_i && $stable(w_i))
  );

endmodule

/* hdl/floo_chimney_pkg.sv */
//////////////////////////////////////////////////
// Shared widths, channel tags, AXI channel and
// flit structs, and the system address map lookup
//////////////////////////////////////////////////

package floo_chimney_pkg;

  // AXI and NoC widths
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned AxiIdWidth   = 4;
  localparam int unsigned NodeIdWidth  = 4;
  localparam int unsigned PayloadWidth = 64;

  typedef logic [NodeIdWidth-1:0] node_id_t;

  // Channel carried by a flit
  typedef enum logic [2:0] {
    AxiAw,
    AxiW,
    AxiAr,
    AxiB,
    AxiR
  } axi_ch_e;

  //////////////////////////////////////////////////
  // AXI channels, reduced to the carried fields
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [AxiIdWidth-1:0] id;
    logic [AddrWidth-1:0]  addr;
    logic [7:0]            len;
  } axi_ax_chan_t;

  typedef struct packed {
    logic [DataWidth-1:0]   data;
    logic [DataWidth/8-1:0] strb;
    logic                   last;
  } axi_w_chan_t;

  typedef struct packed {
    logic [AxiIdWidth-1:0] id;
    logic [1:0]            resp;
  } axi_b_chan_t;

  typedef struct packed {
    logic [AxiIdWidth-1:0] id;
    logic [DataWidth-1:0]  data;
    logic [1:0]            resp;
    logic                  last;
  } axi_r_chan_t;

  //////////////////////////////////////////////////
  // Flits
  //////////////////////////////////////////////////

  typedef struct packed {
    node_id_t dst_id;
    node_id_t src_id;
    axi_ch_e  axi_ch;
    logic     last;
  } floo_hdr_t;

  // Channel struct sits in the low payload bits, the rest is zero
  typedef struct packed {
    floo_hdr_t                hdr;
    logic [PayloadWidth-1:0]  payload;
  } floo_flit_t;

  // Address map, each rule covers one 256 MiB region
  localparam int unsigned SamNumRules = 4;
  localparam logic [AddrWidth:0] SamRuleSize = 33'h1000_0000;

  // Rule i maps to node i+1, anything unmapped goes to node 0
  function automatic node_id_t sam_lookup(input logic [AddrWidth-1:0] addr);
    node_id_t           node;
    logic [AddrWidth:0] base;
    logic [AddrWidth:0] limit;
    node = '0;
    for (int i = 0; i < SamNumRules; i++) begin
      base  = (AddrWidth+1)'(i) * SamRuleSize;
      limit = base + SamRuleSize;
      if (({1'b0, addr} >= base) && ({1'b0, addr} < limit)) begin
        node = node_id_t'(i + 1);
      end
    end
    return node;
  endfunction

endpackage
